// File: logic/arith_defs.svh
// arithmetic coder constants
`ifndef ARITH_DEFS_SVH
`define ARITH_DEFS_SVH

// interval register width and bounds
`define PRECISION       32
`define WHOLE           32'h8000_0000
`define HALF            32'h4000_0000
`define QUARTER         32'h2000_0000
`define THREE_QUARTERS  32'h6000_0000

// alphabet, data symbols 0..15 plus EOF
`define NUM_SYMBOLS     17
`define EOF_SYMBOL      16
`define SYM_W           5

`define FREQ_W          16    // cumulative count width
`define PROD_W          48    // w times a count
`define WORD_W          32    // packed output word
`define OUT_CREDIT_MAX  4     // credits the packer can bank

`endif

// File: logic/arithPkg.sv
// arithmetic coder types
`include "arith_defs.svh"

package arithPkg;

    // interval coder FSM
    typedef enum logic [2:0] {
        WaitSymbol,
        Multiply,
        DivHigh,
        DivLow,
        Rescale,
        EmitPending,
        Terminate,
        Flush
    } coderState;

    typedef logic [`SYM_W-1:0]     symbolT;
    typedef logic [`FREQ_W-1:0]    freqT;     // cumulative count
    typedef logic [`PRECISION-1:0] intervalT; // a, b and w
    typedef logic [`PROD_W-1:0]    productT;  // w * count

endpackage

// File: logic/freqModel.sv
// adaptive frequency model
`timescale 1ns/1ps
`include "arith_defs.svh"

module freqModel (
    input  logic            clk,
    input  logic            rstn,
    input  logic            modelClear,
    input  logic            modelUpdate,
    input  arithPkg::symbolT symbol,
    output arithPkg::freqT  lowCount,
    output arithPkg::freqT  highCount,
    output arithPkg::freqT  totalCount
);

    // cum[i] is the sum of the counts of all symbols below i
    arithPkg::freqT cum [0:`NUM_SYMBOLS];

    arithPkg::symbolT nextSymbol;

    assign nextSymbol = symbol + 5'd1;

    always_ff @(posedge clk) begin
        if (!rstn || modelClear) begin
            for (int i = 0; i <= `NUM_SYMBOLS; i++) begin
                cum[i] <= arithPkg::freqT'(i); // every count back to 1
            end
        end else if (modelUpdate) begin
            // bumping all entries above the symbol grows its own count by one
            for (int i = 0; i <= `NUM_SYMBOLS; i++) begin
                if (i > symbol) begin
                    cum[i] <= cum[i] + 1'b1;
                end
            end
        end
    end

    assign lowCount   = cum[symbol];
    assign highCount  = cum[nextSymbol];
    assign totalCount = cum[`NUM_SYMBOLS];

endmodule

// File: logic/seqDivider.sv
// restoring sequential divider
`timescale 1ns/1ps
`include "arith_defs.svh"

module seqDivider (
    input  logic              clk,
    input  logic              rstn,
    input  logic              divStart,
    input  arithPkg::productT dividend,
    input  arithPkg::freqT    divisor,
    output logic              divDone,
    output arithPkg::intervalT quotient
);

    arithPkg::productT quo;    // dividend shifts out, quotient shifts in
    arithPkg::freqT    rem;
    arithPkg::freqT    divReg;
    logic [5:0]        count;  // iterations left
    logic              busy;

    logic [`FREQ_W:0]  trial;

    assign trial = {rem, quo[`PROD_W-1]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            divDone <= 1'b0;
            count   <= '0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                quo    <= dividend;
                rem    <= '0;
                divReg <= divisor;
                count  <= 6'(`PROD_W);
                busy   <= 1'b1;
            end else if (busy) begin
                if (trial >= {1'b0, divReg}) begin
                    rem <= arithPkg::freqT'(trial - {1'b0, divReg});
                    quo <= {quo[`PROD_W-2:0], 1'b1};
                end else begin
                    rem <= trial[`FREQ_W-1:0];
                    quo <= {quo[`PROD_W-2:0], 1'b0};
                end
                count <= count - 1'b1;
                if (count == 6'd1) begin // last quotient bit lands this cycle
                    busy    <= 1'b0;
                    divDone <= 1'b1;
                end
            end
        end
    end

    // quotient never exceeds w, so the low bits hold all of it
    assign quotient = quo[`PRECISION-1:0];

endmodule

// File: logic/intervalCoder.sv
// interval coder FSM
`timescale 1ns/1ps
`include "arith_defs.svh"

module intervalCoder (
    input  logic               clk,
    input  logic               rstn,
    input  logic               symValid,
    input  arithPkg::symbolT   symbol,
    output logic               symCredit,
    output logic               idle,
    output logic               modelClear,
    output logic               modelUpdate,
    output arithPkg::symbolT   modelSymbol,
    input  arithPkg::freqT     lowCount,
    input  arithPkg::freqT     highCount,
    input  arithPkg::freqT     totalCount,
    output logic               divStart,
    output arithPkg::productT  dividend,
    output arithPkg::freqT     divisor,
    input  logic               divDone,
    input  arithPkg::intervalT quotient,
    output logic               bitValid,
    output logic               bitValue,
    output logic               bitLast,
    input  logic               bitReady
);

    arithPkg::coderState state;

    arithPkg::intervalT a;
    arithPkg::intervalT b;
    arithPkg::intervalT width;
    arithPkg::productT  lowProd;   // waits for the second division
    arithPkg::symbolT   curSymbol;

    logic [15:0] pending;          // middle-case bits owed
    logic        pendValue;        // value of the owed bits
    logic        granted;          // one symbol credit outstanding
    logic        inMessage;
    logic        closing;          // termination bits under way
    logic        acceptSym;

    assign width       = b - a;
    assign modelSymbol = curSymbol;
    assign acceptSym   = (state == arithPkg::WaitSymbol) && granted && symValid;
    assign modelClear  = acceptSym && !inMessage; // fresh model for a new message
    assign idle        = (state == arithPkg::WaitSymbol) && !inMessage;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= arithPkg::WaitSymbol;
            granted     <= 1'b0;
            inMessage   <= 1'b0;
            closing     <= 1'b0;
            symCredit   <= 1'b0;
            divStart    <= 1'b0;
            modelUpdate <= 1'b0;
            bitValid    <= 1'b0;
            bitLast     <= 1'b0;
            pending     <= '0;
        end else begin
            symCredit   <= 1'b0;
            divStart    <= 1'b0;
            modelUpdate <= 1'b0;

            unique case (state)
                arithPkg::WaitSymbol: begin
                    if (!granted) begin
                        symCredit <= 1'b1;
                        granted   <= 1'b1;
                    end else if (symValid) begin
                        granted   <= 1'b0;
                        curSymbol <= symbol;
                        if (!inMessage) begin // start from the whole interval
                            a         <= '0;
                            b         <= `WHOLE;
                            pending   <= '0;
                            inMessage <= 1'b1;
                        end
                        state <= arithPkg::Multiply;
                    end
                end

                arithPkg::Multiply: begin
                    dividend <= arithPkg::productT'(width) * arithPkg::productT'(highCount);
                    lowProd  <= arithPkg::productT'(width) * arithPkg::productT'(lowCount);
                    divisor  <= totalCount;
                    divStart <= 1'b1;
                    state    <= arithPkg::DivHigh;
                end

                arithPkg::DivHigh: begin
                    if (divDone) begin
                        b        <= a + quotient;
                        dividend <= lowProd;
                        divStart <= 1'b1;
                        state    <= arithPkg::DivLow;
                    end
                end

                arithPkg::DivLow: begin
                    if (divDone) begin
                        a           <= a + quotient;
                        modelUpdate <= (curSymbol != `EOF_SYMBOL); // EOF leaves the model alone
                        state       <= arithPkg::Rescale;
                    end
                end

                arithPkg::Rescale: begin
                    if (b < `HALF) begin
                        // lower half, emit 0 then owed ones
                        a         <= a << 1;
                        b         <= b << 1;
                        bitValue  <= 1'b0;
                        pendValue <= 1'b1;
                        bitValid  <= 1'b1;
                        state     <= arithPkg::EmitPending;
                    end else if (a > `HALF) begin
                        // upper half, emit 1 then owed zeros
                        a         <= (a - `HALF) << 1;
                        b         <= (b - `HALF) << 1;
                        bitValue  <= 1'b1;
                        pendValue <= 1'b0;
                        bitValid  <= 1'b1;
                        state     <= arithPkg::EmitPending;
                    end else if ((a > `QUARTER) && (b < `THREE_QUARTERS)) begin
                        a       <= (a - `QUARTER) << 1;
                        b       <= (b - `QUARTER) << 1;
                        pending <= pending + 1'b1;
                    end else if (curSymbol == `EOF_SYMBOL) begin
                        state <= arithPkg::Terminate;
                    end else begin
                        state <= arithPkg::WaitSymbol; // next credit goes out from there
                    end
                end

                arithPkg::Terminate: begin
                    // one more owed bit picks the quarter inside [a, b)
                    closing   <= 1'b1;
                    pending   <= pending + 1'b1;
                    bitValue  <= (a > `QUARTER);
                    pendValue <= !(a > `QUARTER);
                    bitValid  <= 1'b1;
                    state     <= arithPkg::EmitPending;
                end

                arithPkg::EmitPending: begin
                    if (bitReady) begin // bit held until the packer takes it
                        if (pending != '0) begin
                            bitValue <= pendValue;
                            pending  <= pending - 1'b1;
                            bitLast  <= closing && (pending == 16'd1);
                        end else begin
                            bitValid <= 1'b0;
                            bitLast  <= 1'b0;
                            state    <= closing ? arithPkg::Flush : arithPkg::Rescale;
                        end
                    end
                end

                arithPkg::Flush: begin
                    closing   <= 1'b0;
                    inMessage <= 1'b0;
                    state     <= arithPkg::WaitSymbol;
                end

                default: begin
                    state <= arithPkg::WaitSymbol;
                end
            endcase
        end
    end

endmodule

// File: logic/wordPacker.sv
// bit to word packer
`timescale 1ns/1ps
`include "arith_defs.svh"

module wordPacker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               bitValid,
    input  logic               bitValue,
    input  logic               bitLast,
    output logic               bitReady,
    input  logic               outCredit,
    output logic               wordValid,
    output logic [`WORD_W-1:0] word,
    output logic [2:0]         validBytes
);

    logic [`WORD_W-1:0] wordReg;
    logic [5:0]         bitCount;  // bits in the current word
    logic               full;      // word complete, waiting for a credit
    logic [2:0]         credits;
    logic               sendNow;

    assign bitReady = !full;
    assign sendNow  = full && (credits != 3'd0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wordReg   <= '0;
            bitCount  <= '0;
            full      <= 1'b0;
            credits   <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;

            if (bitValid && bitReady) begin
                wordReg[bitCount[4:0]] <= bitValue; // first bit lands in bit 0
                bitCount <= bitCount + 1'b1;
                if (bitLast || (bitCount == 6'd31)) begin
                    full <= 1'b1;
                end
            end

            if (sendNow) begin
                wordValid  <= 1'b1;
                word       <= wordReg;
                validBytes <= 3'((bitCount + 6'd7) >> 3); // bytes rounded up
                wordReg    <= '0; // unused bits stay zero
                bitCount   <= '0;
                full       <= 1'b0;
            end

            // sink credits in, one out per word sent
            if (outCredit && !sendNow) begin
                if (credits < 3'(`OUT_CREDIT_MAX)) begin
                    credits <= credits + 1'b1;
                end
            end else if (!outCredit && sendNow) begin
                credits <= credits - 1'b1;
            end
        end
    end

endmodule

// File: logic/arithEncoder.sv
// arithmetic encoder top
`timescale 1ns/1ps
`include "arith_defs.svh"

module arithEncoder (
    input  logic               clk,
    input  logic               rstn,
    input  logic               symValid,
    input  arithPkg::symbolT   symbol,
    output logic               symCredit,
    output logic               idle,
    input  logic               outCredit,
    output logic               wordValid,
    output logic [`WORD_W-1:0] word,
    output logic [2:0]         validBytes
);

    logic               modelClear;
    logic               modelUpdate;
    arithPkg::symbolT   modelSymbol;
    arithPkg::freqT     lowCount;
    arithPkg::freqT     highCount;
    arithPkg::freqT     totalCount;
    logic               divStart;
    arithPkg::productT  dividend;
    arithPkg::freqT     divisor;
    logic               divDone;
    arithPkg::intervalT quotient;
    logic               bitValid;
    logic               bitValue;
    logic               bitLast;
    logic               bitReady;

    freqModel model_i (
        .clk        (clk),
        .rstn       (rstn),
        .modelClear (modelClear),
        .modelUpdate(modelUpdate),
        .symbol     (modelSymbol),
        .lowCount   (lowCount),
        .highCount  (highCount),
        .totalCount (totalCount)
    );

    seqDivider divider_i (
        .clk     (clk),
        .rstn    (rstn),
        .divStart(divStart),
        .dividend(dividend),
        .divisor (divisor),
        .divDone (divDone),
        .quotient(quotient)
    );

    intervalCoder coder_i (
        .clk        (clk),
        .rstn       (rstn),
        .symValid   (symValid),
        .symbol     (symbol),
        .symCredit  (symCredit),
        .idle       (idle),
        .modelClear (modelClear),
        .modelUpdate(modelUpdate),
        .modelSymbol(modelSymbol),
        .lowCount   (lowCount),
        .highCount  (highCount),
        .totalCount (totalCount),
        .divStart   (divStart),
        .dividend   (dividend),
        .divisor    (divisor),
        .divDone    (divDone),
        .quotient   (quotient),
        .bitValid   (bitValid),
        .bitValue   (bitValue),
        .bitLast    (bitLast),
        .bitReady   (bitReady)
    );

    wordPacker packer_i (
        .clk       (clk),
        .rstn      (rstn),
        .bitValid  (bitValid),
        .bitValue  (bitValue),
        .bitLast   (bitLast),
        .bitReady  (bitReady),
        .outCredit (outCredit),
        .wordValid (wordValid),
        .word      (word),
        .validBytes(validBytes)
    );

endmodule

// File: bench/arithEncoderTb.sv
// arithmetic encoder testbench
`timescale 1ns/1ps
`include "arith_defs.svh"

module arithEncoderTb;

    logic               clk;
    logic               rstn;
    logic               symValid;
    logic [`SYM_W-1:0]  symbol;
    logic               symCredit;
    logic               idle;
    logic               outCredit;
    logic               wordValid;
    logic [`WORD_W-1:0] word;
    logic [2:0]         validBytes;

    logic [31:0]        rngState;
    logic [`SYM_W-1:0]  allSyms [$];    // all messages back to back
    int                 symGaps [$];    // idle cycles before each symbol
    int                 msgLen [$];     // symbols per message including EOF
    bit                 msgSlow [$];
    int                 creditGaps [$];
    bit                 refBits [$];
    logic [`WORD_W-1:0] expWords [$];
    int                 expBytes [$];
    int                 expBits [$];    // bits per message
    bit                 slowCredits;
    bit                 creditOutstanding = 1'b0;
    bit                 msgOpen = 1'b0; // a message is being coded
    int                 creditsGiven = 0;
    int                 wordsSeen = 0;
    int                 bitsSeen = 0;
    int                 cycleCount = 0;
    int                 cycleLimit = 1000;

    arithEncoder dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .symValid  (symValid),
        .symbol    (symbol),
        .symCredit (symCredit),
        .idle      (idle),
        .outCredit (outCredit),
        .wordValid (wordValid),
        .word      (word),
        .validBytes(validBytes)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState >> 8; // low bits of an LCG repeat quickly
    endfunction

    function automatic void emitWithPending(input bit first, input int count);
        refBits.push_back(first);
        for (int i = 0; i < count; i++) begin
            refBits.push_back(!first);
        end
    endfunction

    // expected words, byte counts and bit count for one message
    function automatic void encodeRef(input int first, input int count);
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned span;
        longint unsigned lowCum;
        longint unsigned total;
        int              freq [`NUM_SYMBOLS];
        int              pending;
        int              sym;
        int              nb;
        int              chunk;
        bit              scaling;
        logic [`WORD_W-1:0] wordBits;
        lo = 0;
        hi = `WHOLE;
        pending = 0;
        refBits.delete();
        foreach (freq[i]) begin
            freq[i] = 1; // every count starts at one
        end
        for (int n = 0; n < count; n++) begin
            sym = allSyms[first + n];
            lowCum = 0;
            total = 0;
            for (int i = 0; i < `NUM_SYMBOLS; i++) begin
                if (i < sym) begin
                    lowCum += freq[i];
                end
                total += freq[i];
            end
            span = hi - lo;
            hi = lo + span * (lowCum + freq[sym]) / total;
            lo = lo + span * lowCum / total;
            if (sym != `EOF_SYMBOL) begin
                freq[sym]++;
            end
            scaling = 1'b1;
            while (scaling) begin
                if (hi < `HALF) begin
                    emitWithPending(1'b0, pending);
                    pending = 0;
                    lo = lo * 2;
                    hi = hi * 2;
                end else if (lo > `HALF) begin
                    emitWithPending(1'b1, pending);
                    pending = 0;
                    lo = (lo - `HALF) * 2;
                    hi = (hi - `HALF) * 2;
                end else if (lo > `QUARTER && hi < `THREE_QUARTERS) begin
                    pending++;
                    lo = (lo - `QUARTER) * 2;
                    hi = (hi - `QUARTER) * 2;
                end else begin
                    scaling = 1'b0;
                end
            end
        end
        emitWithPending(lo > `QUARTER, pending + 1); // termination after EOF
        nb = refBits.size();
        expBits.push_back(nb);
        for (int base = 0; base < nb; base += `WORD_W) begin
            chunk = (nb - base < `WORD_W) ? nb - base : `WORD_W;
            wordBits = '0;
            for (int k = 0; k < chunk; k++) begin
                wordBits[k] = refBits[base + k];
            end
            expWords.push_back(wordBits);
            expBytes.push_back((chunk + 7) / 8);
        end
    endfunction

    function automatic void addMessage(input int dataLen, input int repeatSym, input bit slow);
        for (int i = 0; i < dataLen; i++) begin
            if (repeatSym < 0) begin
                allSyms.push_back(`SYM_W'(nextRand() % 16));
            end else begin
                allSyms.push_back(`SYM_W'(repeatSym));
            end
            symGaps.push_back(nextRand() % 4);
        end
        allSyms.push_back(`SYM_W'(`EOF_SYMBOL));
        symGaps.push_back(nextRand() % 4);
        msgLen.push_back(dataLen + 1);
        msgSlow.push_back(slow);
    endfunction

    task automatic checkValue(input string name, input longint unsigned got,
                              input longint unsigned expected);
        if (got != expected) begin
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stopWithError(input string why);
        $display("%s at time %0t", why, $time);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic sendSymbol(input logic [`SYM_W-1:0] s, input int gap);
        @(posedge clk);
        while (!creditOutstanding) begin
            @(posedge clk);
        end
        repeat (gap) @(posedge clk);
        symValid <= 1'b1;
        symbol   <= s;
        @(posedge clk);
        symValid <= 1'b0;
    endtask

    // output credits come fast or after long gaps
    initial begin
        int gap;
        int gapIdx;
        gap = 0;
        gapIdx = 0;
        outCredit = 1'b0;
        forever begin
            @(posedge clk);
            outCredit <= 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (rstn && (creditsGiven - wordsSeen < `OUT_CREDIT_MAX)) begin
                outCredit <= 1'b1;
                creditsGiven++;
                if (slowCredits) begin
                    gap = creditGaps[gapIdx % creditGaps.size()];
                    gapIdx++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (symCredit && creditOutstanding) begin
            stopWithError("second symbol credit came before a symbol was sent");
        end else if (msgOpen && idle) begin
            stopWithError("idle was high while a message was still being coded");
        end else begin
            if (symCredit) begin
                creditOutstanding = 1'b1;
            end
            if (symValid) begin
                creditOutstanding = 1'b0; // symbol uses up the credit
                msgOpen = 1'b1;
            end
            if (dut_i.bitValid && dut_i.bitReady) begin
                bitsSeen++;
                if (dut_i.bitLast) begin
                    checkValue("bitCount", bitsSeen, expBits.pop_front());
                    bitsSeen = 0;
                    msgOpen = 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (wordValid) begin
            wordsSeen++;
            if (wordsSeen > creditsGiven) begin
                stopWithError("a word was sent without an output credit");
            end else if (expWords.size() == 0) begin
                stopWithError("a word was sent that no message accounts for");
            end else begin
                checkValue("word", word, expWords.pop_front());
                checkValue("validBytes", validBytes, expBytes.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("ERRORS FOUND");
            $fatal(1, "timeout, the messages did not finish within %0d cycles", cycleLimit);
        end
    end

    initial begin
        int first;
        int start;
        int len;
        rngState = 32'd47;
        rstn = 1'b0;
        symValid = 1'b0;
        symbol = '0;
        slowCredits = 1'b0;
        addMessage(0, 0, 1'b0);                 // EOF only
        addMessage(40, -1, 1'b0);
        addMessage(60, nextRand() % 16, 1'b0);  // adaptive model
        start = allSyms.size();
        addMessage(60 + nextRand() % 31, -1, 1'b1);
        len = allSyms.size() - start;
        for (int i = 0; i < len; i++) begin
            allSyms.push_back(allSyms[start + i]);
            symGaps.push_back(symGaps[start + i]);
        end
        msgLen.push_back(len);
        msgSlow.push_back(1'b0);
        for (int i = 0; i < 16; i++) begin
            creditGaps.push_back(600 + nextRand() % 900);
        end
        cycleLimit = allSyms.size() * 600 + 2000;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        first = 0;
        foreach (msgLen[m]) begin
            do begin
                @(negedge clk);
            end while (!idle); // coder back to idle before a new message
            slowCredits = msgSlow[m];
            encodeRef(first, msgLen[m]);
            for (int n = 0; n < msgLen[m]; n++) begin
                sendSymbol(allSyms[first + n], symGaps[first + n]);
            end
            first += msgLen[m];
        end
        do begin
            @(negedge clk);
        end while (!idle || expWords.size() != 0);
        repeat (4) @(negedge clk);
        if (expBits.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "bit counts left unchecked at the end of the run");
        end
    end

endmodule

// File: arithEncoder.f
+incdir+logic
logic/arithPkg.sv
logic/freqModel.sv
logic/seqDivider.sv
logic/intervalCoder.sv
logic/wordPacker.sv
logic/arithEncoder.sv
bench/arithEncoderTb.sv

// File: run.sh
#!/bin/sh
# build and run the arithmetic encoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module arithEncoderTb -f arithEncoder.f
./obj_dir/VarithEncoderTb
